// ==== Bender.yml ====
package:
  name: la_rle

sources:
  # package first, then the blocks, then the top level
  - hdl/la_pkg.sv
  - hdl/la_decimator.sv
  - hdl/rle_encoder.sv
  - hdl/stream_fifo.sv
  - hdl/la_axil_regs.sv
  - hdl/la_rle_top.sv

  # testbench, top module la_rle_tb
  - target: simulation
    files:
      - verification/la_rle_tb.sv

// ==== hdl/la_axil_regs.sv ====
// la_axil_regs: axi4-lite slave with config, status, overflow flag and word pop
`timescale 1ns/100ps
`default_nettype none

module la_axil_regs (
  input  logic                        sti,
  input  logic                        ctl_rst,
  // axi4-lite write address and data
  input  logic [la_pkg::ADDR_W-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [la_pkg::DAT_W-1:0]    wdata,
  input  logic [la_pkg::DAT_W/8-1:0]  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  // write response
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  // read address and data
  input  logic [la_pkg::ADDR_W-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [la_pkg::DAT_W-1:0]    rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  // configuration
  output logic                        cfg_acq,
  output logic                        cfg_ena,
  output logic [la_pkg::DEC_W-1:0]    cfg_decim,
  output logic [la_pkg::LEN_W-1:0]    cfg_len,
  // status
  input  logic                        smp_drop,
  input  logic                        fifo_vld,
  output logic                        fifo_rdy,
  input  logic [la_pkg::ENC_W-1:0]    fifo_dat,
  input  logic [la_pkg::LVL_W-1:0]    fifo_lvl
);

  import la_pkg::*;

  logic             wr_acc;
  logic             ar_acc;
  logic             ovf;
  logic             ovf_clr;
  logic [DAT_W-1:0] rd_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////////////////////

  // address and data together, response slot empty
  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign bresp   = 2'b00;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      bvalid <= 1'b0;
    end else if (wr_acc) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // config registers, byte lanes per wstrb
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cfg_acq   <= 1'b0;
      cfg_ena   <= 1'b0;
      cfg_decim <= '0;
      cfg_len   <= '0;
    end else if (wr_acc) begin
      case (awaddr)
        REG_CTRL: begin
          if (wstrb[0]) begin
            cfg_acq <= wdata[CTRL_ACQ];
            cfg_ena <= wdata[CTRL_ENA];
          end
        end
        REG_DECIM: begin
          for (int b = 0; b < DEC_W/8; b++) begin
            if (wstrb[b]) cfg_decim[8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        REG_LENGTH: begin
          for (int b = 0; b < LEN_W/8; b++) begin
            if (wstrb[b]) cfg_len[8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        default: begin
          cfg_acq <= cfg_acq;
        end
      endcase
    end
  end

  // sticky overflow, a new drop wins over clear
  assign ovf_clr = wr_acc & (awaddr == REG_CTRL) & wstrb[0] & wdata[CTRL_CLR];

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      ovf <= 1'b0;
    end else if (smp_drop) begin
      ovf <= 1'b1;
    end else if (ovf_clr) begin
      ovf <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////////////////////

  assign ar_acc   = arvalid & ~rvalid;
  assign arready  = ar_acc;
  assign rresp    = 2'b00;
  // data read pops the head word, only when there is one
  assign fifo_rdy = ar_acc & (araddr == REG_DATA) & fifo_vld;

  // read mux, unknown offsets read zero
  always_comb begin
    rd_nxt = '0;
    case (araddr)
      REG_CTRL: begin
        rd_nxt[CTRL_ACQ] = cfg_acq;
        rd_nxt[CTRL_ENA] = cfg_ena;
      end
      REG_DECIM:  rd_nxt[DEC_W-1:0] = cfg_decim;
      REG_LENGTH: rd_nxt[LEN_W-1:0] = cfg_len;
      REG_STATUS: begin
        rd_nxt[LVL_W-1:0] = fifo_lvl;
        rd_nxt[STAT_OVF]  = ovf;
      end
      REG_DATA: begin
        rd_nxt[ENC_W-1:0] = fifo_dat;
        rd_nxt[DATA_VLD]  = fifo_vld;
      end
      default: rd_nxt = '0;
    endcase
  end

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      rvalid <= 1'b0;
    end else if (ar_acc) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge sti) begin
    if (ar_acc) begin
      rdata <= rd_nxt;
    end
  end

  // responses wait for the master
  a_b_hold: assert property (@(posedge sti) disable iff (ctl_rst)
    (bvalid && !bready) |=> bvalid);
  a_r_hold: assert property (@(posedge sti) disable iff (ctl_rst)
    (rvalid && !rready) |=> rvalid);

endmodule

`default_nettype wire

// ==== hdl/la_decimator.sv ====
// la_decimator: keeps one sample in decim+1, marks record ends, reports drops
`timescale 1ns/100ps
`default_nettype none

module la_decimator (
  input  logic                     sti,
  input  logic                     ctl_rst,
  // configuration
  input  logic                     cfg_acq,
  input  logic [la_pkg::DEC_W-1:0] cfg_decim,
  input  logic [la_pkg::LEN_W-1:0] cfg_len,
  // sampled bus, no back-pressure
  input  logic [la_pkg::SMP_W-1:0] smp_dat,
  // kept samples toward the encoder
  output logic                     dec_vld,
  input  logic                     dec_rdy,
  output logic [la_pkg::SMP_W-1:0] dec_dat,
  output logic                     dec_lst,
  output logic                     smp_drop
);

  import la_pkg::*;

  // cycles left until the next kept sample
  logic [DEC_W-1:0] skp_cnt;
  // kept samples in the current record
  logic [LEN_W-1:0] rec_cnt;
  logic             keep;
  logic             rec_end;

  ////////////////////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////////////////////

  // first sample after enable is kept at once
  assign keep    = cfg_acq & (skp_cnt == '0);
  // length 0 disables record marks
  assign rec_end = (cfg_len != '0) & (rec_cnt == cfg_len - LEN_W'(1));

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      skp_cnt <= '0;
      rec_cnt <= '0;
      dec_vld <= 1'b0;
      dec_lst <= 1'b0;
    end else begin
      // single cycle pulse per kept sample
      dec_vld <= keep;
      if (!cfg_acq) begin
        // restart both counters while stopped
        skp_cnt <= '0;
        rec_cnt <= '0;
      end else if (keep) begin
        skp_cnt <= cfg_decim;
        rec_cnt <= rec_end ? '0 : rec_cnt + LEN_W'(1);
        dec_lst <= rec_end;
      end else begin
        skp_cnt <= skp_cnt - DEC_W'(1);
      end
    end
  end

  // sample payload
  always_ff @(posedge sti) begin
    if (keep) begin
      dec_dat <= smp_dat;
    end
  end

  // encoder busy, this sample is gone
  assign smp_drop = dec_vld & ~dec_rdy;

  // with a stable nonzero ratio, kept samples are spaced apart
  a_dec_gap: assert property (@(posedge sti) disable iff (ctl_rst)
    (dec_vld && cfg_decim != '0 && $stable(cfg_decim)) |=> !dec_vld);

endmodule

`default_nettype wire

// ==== hdl/la_pkg.sv ====
// la_pkg: sample, run and word widths, fifo depth, axi4-lite register map
`default_nettype none

package la_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream widths
  ////////////////////////////////////////////////////////////////////////////

  // raw sample from the input bus
  localparam int SMP_W = 8;
  // run counter, a run holds up to 256 samples
  localparam int CNT_W = 8;
  // encoded word {last, count, value}
  localparam int ENC_W = CNT_W + SMP_W + 1;

  // word buffer
  localparam int FIFO_DEPTH = 16;
  localparam int LVL_W      = 5;

  // decimation ratio and record length
  localparam int DEC_W = 16;
  localparam int LEN_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // cpu port and register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 8;
  localparam int DAT_W  = 32;

  localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;
  localparam logic [ADDR_W-1:0] REG_DECIM  = 8'h04;
  localparam logic [ADDR_W-1:0] REG_LENGTH = 8'h08;
  localparam logic [ADDR_W-1:0] REG_STATUS = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_DATA   = 8'h10;

  // bit positions inside the registers
  localparam int CTRL_ACQ = 0;
  localparam int CTRL_ENA = 1;
  localparam int CTRL_CLR = 2;
  localparam int STAT_OVF = 8;
  localparam int DATA_VLD = 31;

endpackage

`default_nettype wire

// ==== hdl/la_rle_top.sv ====
// la_rle_top: decimator, rle encoder, word fifo and axi4-lite register bank
`timescale 1ns/100ps
`default_nettype none

module la_rle_top (
  input  logic                        sti,
  input  logic                        ctl_rst,
  // digital input bus
  input  logic [la_pkg::SMP_W-1:0]    smp_dat,
  // axi4-lite cpu port
  input  logic [la_pkg::ADDR_W-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [la_pkg::DAT_W-1:0]    wdata,
  input  logic [la_pkg::DAT_W/8-1:0]  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [la_pkg::ADDR_W-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [la_pkg::DAT_W-1:0]    rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready
);

  import la_pkg::*;

  // configuration
  logic             cfg_acq;
  logic             cfg_ena;
  logic [DEC_W-1:0] cfg_decim;
  logic [LEN_W-1:0] cfg_len;
  logic             smp_drop;

  // decimator to encoder
  logic             dec_vld;
  logic             dec_rdy;
  logic [SMP_W-1:0] dec_dat;
  logic             dec_lst;

  // encoder to fifo
  logic             enc_vld;
  logic             enc_rdy;
  logic [ENC_W-1:0] enc_dat;

  // fifo to register bank
  logic             fifo_vld;
  logic             fifo_rdy;
  logic [ENC_W-1:0] fifo_dat;
  logic [LVL_W-1:0] fifo_lvl;

  ////////////////////////////////////////////////////////////////////////////
  // acquisition path
  ////////////////////////////////////////////////////////////////////////////

  la_decimator u_la_decimator (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .cfg_acq   (cfg_acq),
    .cfg_decim (cfg_decim),
    .cfg_len   (cfg_len),
    .smp_dat   (smp_dat),
    .dec_vld   (dec_vld),
    .dec_rdy   (dec_rdy),
    .dec_dat   (dec_dat),
    .dec_lst   (dec_lst),
    .smp_drop  (smp_drop)
  );

  rle_encoder u_rle_encoder (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .cfg_ena (cfg_ena),
    .sti_vld (dec_vld),
    .sti_rdy (dec_rdy),
    .sti_dat (dec_dat),
    .sti_lst (dec_lst),
    .sto_vld (enc_vld),
    .sto_rdy (enc_rdy),
    .sto_dat (enc_dat)
  );

  stream_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_stream_fifo (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .wr_vld  (enc_vld),
    .wr_rdy  (enc_rdy),
    .wr_dat  (enc_dat),
    .rd_vld  (fifo_vld),
    .rd_rdy  (fifo_rdy),
    .rd_dat  (fifo_dat),
    .lvl     (fifo_lvl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // cpu side
  ////////////////////////////////////////////////////////////////////////////

  la_axil_regs u_la_axil_regs (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .cfg_acq   (cfg_acq),
    .cfg_ena   (cfg_ena),
    .cfg_decim (cfg_decim),
    .cfg_len   (cfg_len),
    .smp_drop  (smp_drop),
    .fifo_vld  (fifo_vld),
    .fifo_rdy  (fifo_rdy),
    .fifo_dat  (fifo_dat),
    .fifo_lvl  (fifo_lvl)
  );

endmodule

`default_nettype wire

// ==== hdl/rle_encoder.sv ====
// rle_encoder: run-length encoder with valid/ready ports, bypass and stall chain
`timescale 1ns/100ps
`default_nettype none

module rle_encoder (
  input  logic                     sti,
  input  logic                     ctl_rst,
  // 0 selects bypass, one word per sample
  input  logic                     cfg_ena,
  // sample stream
  input  logic                     sti_vld,
  output logic                     sti_rdy,
  input  logic [la_pkg::SMP_W-1:0] sti_dat,
  input  logic                     sti_lst,
  // encoded word stream
  output logic                     sto_vld,
  input  logic                     sto_rdy,
  output logic [la_pkg::ENC_W-1:0] sto_dat
);

  import la_pkg::*;

  // holding stage, last accepted sample of the open run
  logic             old_vld;
  logic             old_rdy;
  logic             old_lst;
  logic [SMP_W-1:0] old_dat;

  logic             sti_trn;
  logic             cmp;
  logic             trn;

  // run length minus one
  logic [CNT_W-1:0] cnt;
  logic             max;

  ////////////////////////////////////////////////////////////////////////////
  // stall chain
  ////////////////////////////////////////////////////////////////////////////

  // output register free or draining
  assign old_rdy = sto_rdy | ~sto_vld;
  // an empty holding stage always takes a sample
  assign sti_rdy = old_rdy | ~old_vld;
  assign sti_trn = sti_vld & sti_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // holding register and comparator
  ////////////////////////////////////////////////////////////////////////////

  assign cmp = (old_dat == sti_dat);

  // run closes on bypass, empty stage, full counter, record end or new value
  assign trn = ~cfg_ena | ~old_vld | max | old_lst | (~cmp & sti_vld);

  always_ff @(posedge sti) begin
    if (sti_trn) begin
      old_dat <= sti_dat;
    end
  end

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      old_lst <= 1'b0;
      old_vld <= 1'b0;
    end else begin
      // a merged sample passes its last flag to the run
      if (sti_trn) begin
        old_lst <= sti_lst;
      end
      if (sti_rdy & trn) begin
        old_vld <= sti_vld;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // run counter
  ////////////////////////////////////////////////////////////////////////////

  assign max = &cnt;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cnt <= '0;
    end else if (sti_trn) begin
      cnt <= trn ? '0 : cnt + CNT_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sto_vld <= 1'b0;
    end else if (old_rdy) begin
      sto_vld <= old_vld & trn;
    end
  end

  // closed run as {last, count, value}
  always_ff @(posedge sti) begin
    if (old_rdy & old_vld & trn) begin
      sto_dat <= {old_lst, cnt, old_dat};
    end
  end

  // word held until the buffer takes it
  a_sto_hold: assert property (@(posedge sti) disable iff (ctl_rst)
    (sto_vld && !sto_rdy) |=> (sto_vld && $stable(sto_dat)));

  // a full run restarts instead of wrapping into the next value
  a_cnt_wrap: assert property (@(posedge sti) disable iff (ctl_rst)
    (sti_trn && cnt == '1) |=> (cnt == '0));

endmodule

`default_nettype wire

// ==== hdl/stream_fifo.sv ====
// stream_fifo: show-ahead circular buffer for encoded words, with fill level
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
  // power of two
  parameter int DEPTH = la_pkg::FIFO_DEPTH
) (
  input  logic                     sti,
  input  logic                     ctl_rst,
  // write side
  input  logic                     wr_vld,
  output logic                     wr_rdy,
  input  logic [la_pkg::ENC_W-1:0] wr_dat,
  // read side, head word always on rd_dat
  output logic                     rd_vld,
  input  logic                     rd_rdy,
  output logic [la_pkg::ENC_W-1:0] rd_dat,
  output logic [la_pkg::LVL_W-1:0] lvl
);

  import la_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [ENC_W-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  // one bit wider than the pointers, holds DEPTH
  logic [AW:0]      cnt;
  logic             push;
  logic             pop;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  assign wr_rdy = (cnt != (AW+1)'(DEPTH));
  assign rd_vld = (cnt != '0);
  assign push   = wr_vld & wr_rdy;
  assign pop    = rd_vld & rd_rdy;

  // storage
  always_ff @(posedge sti) begin
    if (push) begin
      mem[wr_ptr] <= wr_dat;
    end
  end

  // pointers wrap on their own
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      case ({push, pop})
        2'b10:   cnt <= cnt + (AW+1)'(1);
        2'b01:   cnt <= cnt - (AW+1)'(1);
        default: cnt <= cnt;
      endcase
    end
  end

  // show-ahead head word
  assign rd_dat = mem[rd_ptr];
  assign lvl    = LVL_W'(cnt);

  a_lvl_max: assert property (@(posedge sti) disable iff (ctl_rst)
    cnt <= (AW+1)'(DEPTH));

  // the consumer only asks for a word when one is there
  a_pop_empty: assert property (@(posedge sti) disable iff (ctl_rst)
    rd_rdy |-> rd_vld);

endmodule

`default_nettype wire

// ==== la_rle.f ====
hdl/la_pkg.sv
hdl/la_decimator.sv
hdl/rle_encoder.sv
hdl/stream_fifo.sv
hdl/la_axil_regs.sv
hdl/la_rle_top.sv
verification/la_rle_tb.sv

// ==== verification/la_rle_tb.sv ====
// testbench: clock and reset, axi4-lite master tasks, encoding model, directed tests, watchdog
`timescale 1ns/100ps
`default_nettype none

module la_rle_tb;

  import la_pkg::*;

  // samples driven per test
  localparam int N_BYP   = 10;
  localparam int N_CMP   = 38;
  localparam int N_CONST = 296;
  localparam int N_REC   = 30;
  localparam int N_DEC   = 30;
  localparam int N_OVF   = 40;
  localparam int RUN_N   = 8;
  localparam int TOTAL_SAMPLES = N_BYP + N_CMP + N_CONST + N_REC + N_DEC + N_OVF;

  logic               sti;
  logic               ctl_rst;
  logic [SMP_W-1:0]   smp_dat;
  logic [ADDR_W-1:0]  awaddr;
  logic               awvalid;
  logic               awready;
  logic [DAT_W-1:0]   wdata;
  logic [DAT_W/8-1:0] wstrb;
  logic               wvalid;
  logic               wready;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;
  logic [ADDR_W-1:0]  araddr;
  logic               arvalid;
  logic               arready;
  logic [DAT_W-1:0]   rdata;
  logic [1:0]         rresp;
  logic               rvalid;
  logic               rready;

  integer             seed;
  // acquisition state as the cpu last set it
  logic               acq_on;
  // free-running ramp on the input bus
  logic               ramp_on;
  logic [SMP_W-1:0]   captured [$];
  logic [ENC_W-1:0]   expected [$];
  logic [ENC_W-1:0]   got [$];

  la_rle_top u_la_rle_top (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .smp_dat (smp_dat),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  // 8 ns period
  always #4 sti = ~sti;

  // every cycle with acquisition on keeps a sample at decim 0
  always @(posedge sti) begin
    if (acq_on) begin
      captured.push_back(smp_dat);
    end
  end

  always @(negedge sti) begin
    if (ramp_on) begin
      smp_dat = smp_dat + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checker and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DAT_W-1:0] data);
    @(negedge sti);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge sti);
      #1;
    end
    // accepted on the edge just passed
    @(negedge sti);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    if (addr == REG_CTRL) begin
      acq_on = data[CTRL_ACQ];
    end
    #1;
    while (!bvalid) begin
      @(negedge sti);
      #1;
    end
    compare("write response", 32'd0, 32'(bresp));
    @(negedge sti);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DAT_W-1:0] data);
    @(negedge sti);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge sti);
      #1;
    end
    @(negedge sti);
    arvalid = 1'b0;
    rready  = 1'b1;
    #1;
    while (!rvalid) begin
      @(negedge sti);
      #1;
    end
    data = rdata;
    compare("read response", 32'd0, 32'(rresp));
    @(negedge sti);
    rready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // encoding model and word handling
  ////////////////////////////////////////////////////////////////////////////

  // runs of equal samples, cut at 256 samples and after a record end
  task automatic build_words(input logic ena, input int len);
    logic [SMP_W-1:0] v;
    int               c;
    logic             lst;
    logic             open;
    logic             l;
    expected.delete();
    open = 1'b0;
    v    = '0;
    c    = 0;
    lst  = 1'b0;
    for (int i = 0; i < captured.size(); i++) begin
      l = (len != 0) && (i % len == len - 1);
      if (ena && open && captured[i] == v && !lst && c < 255) begin
        c   = c + 1;
        lst = l;
      end else begin
        if (open) expected.push_back({lst, CNT_W'(c), v});
        open = 1'b1;
        v    = captured[i];
        c    = 0;
        lst  = l;
      end
    end
    if (open) expected.push_back({lst, CNT_W'(c), v});
  endtask

  // pop words until the valid bit is clear
  task automatic drain_words();
    logic [DAT_W-1:0] d;
    logic             more;
    got.delete();
    more = 1'b1;
    while (more) begin
      axil_read(REG_DATA, d);
      if (d[DATA_VLD]) got.push_back(d[ENC_W-1:0]);
      else more = 1'b0;
    end
  endtask

  task automatic compare_words(input string name);
    compare({name, " word count"}, expected.size(), got.size());
    for (int i = 0; i < got.size(); i++) begin
      compare({name, " word"}, 32'(expected[i]), 32'(got[i]));
    end
  endtask

  task automatic start_acq(input logic ena);
    captured.delete();
    axil_write(REG_CTRL, (32'(ena) << CTRL_ENA) | 32'h1);
  endtask

  // stop sampling first, then bypass closes the run still held in the encoder
  task automatic stop_acq(input logic ena);
    axil_write(REG_CTRL, 32'(ena) << CTRL_ENA);
    repeat (4) @(negedge sti);
    axil_write(REG_CTRL, 32'h0);
    repeat (4) @(negedge sti);
    drain_words();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic regs_readback();
    logic [DAT_W-1:0] d;
    axil_read(REG_STATUS, d);
    compare("regs status after reset", 32'h0, d);
    axil_write(REG_DECIM, 32'h1234);
    axil_read(REG_DECIM, d);
    compare("regs decim", 32'h1234, d);
    axil_write(REG_LENGTH, 32'hbeef);
    axil_read(REG_LENGTH, d);
    compare("regs length", 32'hbeef, d);
    axil_write(REG_DECIM, 32'h0);
    axil_write(REG_LENGTH, 32'h0);
  endtask

  task automatic bypass_stream();
    logic [SMP_W-1:0] s [N_BYP];
    for (int i = 0; i < N_BYP; i++) s[i] = $random(seed);
    @(negedge sti) smp_dat = s[0];
    start_acq(1'b0);
    for (int i = 0; i < N_BYP; i++) begin
      @(negedge sti) smp_dat = s[i];
    end
    stop_acq(1'b0);
    build_words(1'b0, 0);
    compare_words("bypass");
  endtask

  task automatic compress_runs();
    int               lens [RUN_N];
    logic [SMP_W-1:0] v;
    lens = '{3, 1, 6, 2, 9, 1, 4, 12};
    v = $random(seed);
    @(negedge sti) smp_dat = v;
    start_acq(1'b1);
    for (int r = 0; r < RUN_N; r++) begin
      for (int k = 0; k < lens[r]; k++) begin
        @(negedge sti) smp_dat = v;
      end
      v = $random(seed);
    end
    stop_acq(1'b1);
    build_words(1'b1, 0);
    compare_words("compress");
  endtask

  task automatic run_record_limits();
    // long constant run splits at 256 samples
    @(negedge sti) smp_dat = 8'h5a;
    start_acq(1'b1);
    repeat (N_CONST) @(negedge sti);
    stop_acq(1'b1);
    build_words(1'b1, 0);
    compare_words("run limit");
    compare("run limit first count", 32'd255, 32'(got[0][15:8]));
    // records of 5, value steps every 8 samples
    axil_write(REG_LENGTH, 32'd5);
    @(negedge sti) smp_dat = '0;
    start_acq(1'b1);
    for (int i = 0; i < N_REC; i++) begin
      @(negedge sti) smp_dat = SMP_W'(i / 8);
    end
    stop_acq(1'b1);
    build_words(1'b1, 5);
    compare_words("record");
    axil_write(REG_LENGTH, 32'h0);
  endtask

  task automatic decim_ramp();
    logic [SMP_W-1:0] step;
    axil_write(REG_DECIM, 32'd2);
    @(negedge sti) ramp_on = 1'b1;
    start_acq(1'b0);
    repeat (N_DEC) @(negedge sti);
    stop_acq(1'b0);
    ramp_on = 1'b0;
    compare("decim enough words", 32'd1, 32'(got.size() >= 3));
    // phase free, only the distance between kept samples
    for (int i = 1; i < got.size(); i++) begin
      step = got[i][SMP_W-1:0] - got[i-1][SMP_W-1:0];
      compare("decim step", 32'd3, 32'(step));
    end
    axil_write(REG_DECIM, 32'h0);
  endtask

  task automatic overflow_fill();
    logic [DAT_W-1:0] d;
    @(negedge sti) ramp_on = 1'b1;
    start_acq(1'b0);
    repeat (N_OVF) @(negedge sti);
    axil_write(REG_CTRL, 32'h0);
    ramp_on = 1'b0;
    axil_read(REG_STATUS, d);
    compare("overflow status", (32'h1 << STAT_OVF) | 32'(FIFO_DEPTH), d);
    // full fifo plus output register and holding stage of the encoder
    drain_words();
    compare("overflow word count", 32'(FIFO_DEPTH + 2), 32'(got.size()));
    axil_write(REG_CTRL, 32'h1 << CTRL_CLR);
    axil_read(REG_STATUS, d);
    compare("overflow clear", 32'h0, d);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    sti     = 1'b0;
    ctl_rst = 1'b1;
    smp_dat = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    seed    = 32'h3cf7f687;
    acq_on  = 1'b0;
    ramp_on = 1'b0;
    repeat (4) @(posedge sti);
    @(negedge sti) ctl_rst = 1'b0;
    regs_readback();
    bypass_stream();
    compress_runs();
    run_record_limits();
    decim_ramp();
    overflow_fill();
    $display("Simulation PASSED");
    $finish;
  end

  // budget of 40 cycles per driven sample
  initial begin
    repeat (TOTAL_SAMPLES * 40) @(posedge sti);
    $display("timeout: tests did not finish within %0d cycles", TOTAL_SAMPLES * 40);
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire
